// File: Makefile
# Verilator build and run for the mini MCU testbench

TOP       ?= tb_mini_mcu
VERILATOR ?= verilator
SEED      ?= 1
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: TOP=$(TOP) VERILATOR=$(VERILATOR) SEED=$(SEED)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/apb_input.txt
# op       addr/value  data/mask  expected  pslverr   (all hex)
# pins: data column is the random pin mask; wait_irq: first column masks irq_o
read       10          0          00000000  0
read       00          0          00000000  0
read       04          0          00000000  0
wait_irq   ffffffff    0          00000000  0
write      00          a5a5f00f   0         0
write      04          ffff0000   0         0
read       00          0          a5a5f00f  0
read       04          0          ffff0000  0
write      00          11111111   0         0
write      00          22222222   0         0
write      00          33333333   0         0
write      00          44444444   0         0
write      00          55555555   0         0
read       00          0          55555555  0
write      08          0000dead   0         1
write      18          0000beef   0         1
read       40          0          00000000  1
write      40          00000001   0         1
read       00          0          55555555  0
read       04          0          ffff0000  0
pins       00000000    ffffff00   0         0
read       08          0          00000000  0
pins       00000004    ffffff00   0         0
read       10          0          00000000  0
pins       00000000    0          0         0
write      0c          00000004   0         0
pins       00000004    0          0         0
wait_irq   01000000    0          01000000  0
read       10          0          00000004  0
write      10          00000004   0         0
read       10          0          00000000  0
wait_irq   01000000    0          00000000  0
write      14          00000001   0         0
irqsrc     ff          0          0         0
read       18          0          003f0888  0
wait_irq   ffffffff    0          003f0888  0
irqsrc     a5          0          0         0
read       18          0          00150808  0

// File: tb/tb_mini_mcu.sv
// ====================
// mini mcu testbench
// replays the input file over APB and checks bus, pin and interrupt results
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mcu;

  import mcu_bus_pkg::*;
  import mcu_pad_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;

  logic        clk_i;
  logic        arst_n_i;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  gpio_word_t  gpio_i;
  gpio_word_t  gpio_o;
  gpio_word_t  gpio_oe_o;
  irq_src_t    irq_src;
  irq_vector_t irq_o;

  // pin bits taken from $urandom, and the full value on the pins
  gpio_word_t  rand_mask;
  gpio_word_t  pins_now;
  int          ops_run;

  mini_mcu_top UUT (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .irq_src_i (irq_src),
    .irq_o     (irq_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input mcu_word_t got, input mcu_word_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %08h, expected %08h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_pins(input gpio_word_t got, input gpio_word_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %08h, expected %08h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_irq(input irq_vector_t got, input irq_vector_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %08h, expected %08h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // random idle cycles between operations
  task automatic idle_gap();
    int n;
    n = $urandom_range(3, 0);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // one APB transfer, SETUP then ACCESS until pready
  task automatic apb_xfer(input logic wr, input mcu_addr_t addr, input mcu_word_t wdata,
                          output apb_rsp_t rsp);
    int waited;
    waited = 0;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk_i);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk_i);
    while (!apb_rsp.pready) begin
      waited++;
      if (waited >= TIMEOUT_CYCLES) begin
        $display("timeout: no pready within %0d cycles at address %02h", TIMEOUT_CYCLES, addr);
        stop_run();
      end
      @(negedge clk_i);
    end
    rsp = apb_rsp;
    @(posedge clk_i);
    #1;
    apb_req = '0;
  endtask

  initial begin
    int               fd;
    int               n;
    int               waited;
    logic [8*128-1:0] line;
    logic [8*12-1:0]  op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      exp_val;
    logic [31:0]      exp_err;
    mcu_word_t        exp_rd;
    apb_rsp_t         rsp;

    void'($urandom(32'h12a2_b48a));
    clk_i     = 1'b0;
    arst_n_i  = 1'b0;
    apb_req   = '0;
    gpio_i    = '0;
    irq_src   = '0;
    rand_mask = '0;
    pins_now  = '0;
    ops_run   = 0;
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    fd = $fopen("tb/apb_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/apb_input.txt");
      stop_run();
    end
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) == 0) break;
      op = '0;
      n  = $sscanf(line, "%s %h %h %h %h", op, a, b, exp_val, exp_err);
      if (n <= 0 || op == "#") continue;
      if (n != 5) begin
        $display("malformed line in tb/apb_input.txt after %0d operations", ops_run);
        stop_run();
      end
      if (op == "write") begin
        apb_xfer(1'b1, a[7:0], b, rsp);
        check_err(rsp.pslverr, exp_err[0], "pslverr on write");
      end else if (op == "read") begin
        idle_gap();
        apb_xfer(1'b0, a[7:0], '0, rsp);
        check_err(rsp.pslverr, exp_err[0], "pslverr on read");
        exp_rd = exp_val;
        if (a[7:0] == ADDR_GPIO_IN) begin
          exp_rd = (exp_val & ~rand_mask) | (pins_now & rand_mask);
        end
        if (!exp_err[0]) begin
          check_word(rsp.prdata, exp_rd, "read data");
        end
        // reads wait for posted writes, so the pins must match too
        if (!exp_err[0] && a[7:0] == ADDR_GPIO_OUT) begin
          check_pins(gpio_o, exp_val, "gpio_o");
        end
        if (!exp_err[0] && a[7:0] == ADDR_GPIO_OE) begin
          check_pins(gpio_oe_o, exp_val, "gpio_oe_o");
        end
      end else if (op == "pins") begin
        idle_gap();
        // random values only on the main bank
        rand_mask = b & 32'hffff_ff00;
        pins_now  = (a & ~rand_mask) | ($urandom & rand_mask);
        gpio_i    = pins_now;
        // two synchronizer edges, one edge-detect edge, one spare
        repeat (4) begin
          @(posedge clk_i);
          #1;
        end
      end else if (op == "irqsrc") begin
        irq_src = irq_src_t'(a[7:0]);
      end else if (op == "wait_irq") begin
        waited = 0;
        @(negedge clk_i);
        while (((irq_o & a) != (exp_val & a)) && (waited < TIMEOUT_CYCLES)) begin
          waited++;
          @(negedge clk_i);
        end
        check_irq(irq_o & a, exp_val & a, "irq_o");
        @(posedge clk_i);
        #1;
      end else begin
        $display("unknown operation in tb/apb_input.txt after %0d operations", ops_run);
        stop_run();
      end
      ops_run++;
    end
    $fclose(fd);

    if (ops_run > 0) begin
      $display("TB PASSED");
    end else begin
      $display("no operations found in tb/apb_input.txt");
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
verilog/mcu_bus_pkg.sv
verilog/mcu_pad_pkg.sv
verilog/cmd_fifo.sv
verilog/apb_reg_front.sv
verilog/gpio_irq_bank.sv
verilog/mini_mcu_top.sv
tb/tb_mini_mcu.sv

// File: verilog/apb_reg_front.sv
// ====================
// APB register front
// decodes accesses, posts writes as commands and serves reads
// ====================
`timescale 1ns/1ps
`default_nettype none

module apb_reg_front (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire mcu_bus_pkg::apb_req_t apb_req_i,
  output mcu_bus_pkg::apb_rsp_t      apb_rsp_o,
  input  wire mcu_pad_pkg::reg_view_t view_i,
  input  wire logic                  fifo_full_i,
  input  wire logic                  fifo_empty_i,
  output mcu_bus_pkg::reg_cmd_t      cmd_o,
  output logic                       cmd_push_o
);

  import mcu_bus_pkg::*;
  import mcu_pad_pkg::*;

  logic      done_q;
  logic      access;
  logic      addr_ok;
  logic      wr_ok;
  logic      err;
  logic      wr_go;
  logic      rd_go;
  logic      ready;
  reg_idx_e  cmd_idx;
  mcu_word_t rdata;

  // address decode
  always_comb begin
    addr_ok = 1'b1;
    wr_ok   = 1'b1;
    cmd_idx = REG_GPIO_OUT;
    rdata   = '0;
    case (apb_req_i.paddr)
      ADDR_GPIO_OUT: rdata = view_i.gpio_out;
      ADDR_GPIO_OE: begin
        cmd_idx = REG_GPIO_OE;
        rdata   = view_i.gpio_oe;
      end
      ADDR_GPIO_IN: begin
        wr_ok = 1'b0;
        rdata = view_i.gpio_in;
      end
      ADDR_IRQ_EN: begin
        cmd_idx = REG_IRQ_EN;
        rdata   = mcu_word_t'(view_i.irq_en);
      end
      ADDR_IRQ_PEND: begin
        cmd_idx = REG_IRQ_PEND;
        rdata   = mcu_word_t'(view_i.irq_pend);
      end
      ADDR_MSIP: begin
        cmd_idx = REG_MSIP;
        rdata   = view_i.msip;
      end
      ADDR_IRQ_VEC: begin
        wr_ok = 1'b0;
        rdata = view_i.irq_vec;
      end
      default: begin
        addr_ok = 1'b0;
        wr_ok   = 1'b0;
      end
    endcase
  end

  assign access = apb_req_i.psel && apb_req_i.penable && !done_q;
  assign err    = access && (!addr_ok || (apb_req_i.pwrite && !wr_ok));
  // writes wait for room, reads wait until all posted writes landed
  assign wr_go  = access && apb_req_i.pwrite && wr_ok && !fifo_full_i;
  assign rd_go  = access && !apb_req_i.pwrite && addr_ok && fifo_empty_i;
  assign ready  = err || wr_go || rd_go;

  assign cmd_push_o = wr_go;
  assign cmd_o      = '{idx: cmd_idx, data: apb_req_i.pwdata};
  assign apb_rsp_o  = '{pready: ready, pslverr: err, prdata: rdata};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b0;
    end else if (!(apb_req_i.psel && apb_req_i.penable)) begin
      done_q <= 1'b0;
    end else if (ready) begin
      done_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cmd_fifo.sv
// ====================
// command FIFO
// first-word-fall-through buffer for posted register writes
// ====================
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
  parameter int DEPTH = mcu_bus_pkg::CMD_FIFO_DEPTH
) (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire logic                  push_i,
  input  wire mcu_bus_pkg::reg_cmd_t data_i,
  output logic                       full_o,
  output logic                       empty_o,
  output logic                       valid_o,
  output mcu_bus_pkg::reg_cmd_t      data_o,
  input  wire logic                  pop_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  mcu_bus_pkg::reg_cmd_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign valid_o = !empty_o;
  assign data_o  = mem[rd_ptr_q];

  // a full FIFO ignores pushes, nothing is overwritten
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

endmodule

`default_nettype wire

// File: verilog/gpio_irq_bank.sv
// ====================
// GPIO and interrupt bank
// pin registers, always-on edge interrupts, core interrupt word
// ====================
`timescale 1ns/1ps
`default_nettype none

module gpio_irq_bank (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    cmd_valid_i,
  input  wire mcu_bus_pkg::reg_cmd_t   cmd_i,
  output logic                         cmd_pop_o,
  input  wire mcu_pad_pkg::gpio_word_t gpio_i,
  output mcu_pad_pkg::gpio_word_t      gpio_o,
  output mcu_pad_pkg::gpio_word_t      gpio_oe_o,
  input  wire mcu_pad_pkg::irq_src_t   irq_src_i,
  output mcu_pad_pkg::irq_vector_t     irq_o,
  output mcu_pad_pkg::reg_view_t       view_o
);

  import mcu_bus_pkg::*;
  import mcu_pad_pkg::*;

  gpio_word_t  gpio_out_q;
  gpio_word_t  gpio_oe_q;
  gpio_ao_t    irq_en_q;
  gpio_ao_t    irq_pend_q;
  logic        msip_q;
  gpio_word_t  sync1_q;
  gpio_word_t  sync2_q;
  gpio_ao_t    ao_last_q;
  gpio_ao_t    ao_rise;
  gpio_ao_t    pend_clr;
  fast_irq_t   fast;
  irq_vector_t irq_vec;

  // one command per cycle
  assign cmd_pop_o = cmd_valid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      irq_en_q   <= '0;
      msip_q     <= 1'b0;
    end else if (cmd_valid_i) begin
      case (cmd_i.idx)
        REG_GPIO_OUT: gpio_out_q <= cmd_i.data;
        REG_GPIO_OE:  gpio_oe_q <= cmd_i.data;
        REG_IRQ_EN:   irq_en_q <= cmd_i.data[GPIO_AO_W-1:0];
        REG_MSIP:     msip_q <= cmd_i.data[0];
        default: ;
      endcase
    end
  end

  // two-flop input synchronizer, plus last value of the always-on pins
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      ao_last_q <= '0;
    end else begin
      sync1_q   <= gpio_i;
      sync2_q   <= sync1_q;
      ao_last_q <= sync2_q[GPIO_AO_W-1:0];
    end
  end

  assign ao_rise = sync2_q[GPIO_AO_W-1:0] & ~ao_last_q;

  always_comb begin
    pend_clr = '0;
    if (cmd_valid_i && cmd_i.idx == REG_IRQ_PEND) begin
      pend_clr = cmd_i.data[GPIO_AO_W-1:0];
    end
  end

  // write-1-to-clear, a new edge in the same cycle wins
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_pend_q <= '0;
    end else begin
      irq_pend_q <= (irq_pend_q & ~pend_clr) | (ao_rise & irq_en_q);
    end
  end

  assign fast = {
    1'b0,
    irq_pend_q,
    irq_src_i.spi_flash,
    irq_src_i.spi,
    irq_src_i.dma_done,
    irq_src_i.timer[3:1]
  };

  always_comb begin
    irq_vec                              = '0;
    irq_vec[IRQ_SOFTWARE_BIT]            = msip_q;
    irq_vec[IRQ_TIMER0_BIT]              = irq_src_i.timer[0];
    irq_vec[IRQ_EXTERNAL_BIT]            = irq_src_i.external;
    irq_vec[IRQ_FAST_LSB+:FAST_W]        = fast;
  end

  assign irq_o     = irq_vec;
  assign gpio_o    = gpio_out_q;
  assign gpio_oe_o = gpio_oe_q;

  assign view_o = '{
    gpio_out: gpio_out_q,
    gpio_oe:  gpio_oe_q,
    gpio_in:  sync2_q,
    irq_en:   irq_en_q,
    irq_pend: irq_pend_q,
    msip:     irq_vector_t'(msip_q),
    irq_vec:  irq_vec
  };

endmodule

`default_nettype wire

// File: verilog/mcu_bus_pkg.sv
// ====================
// mcu bus package
// APB types, register indices, posted write commands and the address map
// ====================
`default_nettype none

package mcu_bus_pkg;

  localparam int MCU_WORD_W = 32;
  localparam int MCU_ADDR_W = 8;

  typedef logic [MCU_WORD_W-1:0] mcu_word_t;
  typedef logic [MCU_ADDR_W-1:0] mcu_addr_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    mcu_addr_t paddr;
    mcu_word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic      pready;
    logic      pslverr;
    mcu_word_t prdata;
  } apb_rsp_t;

  // writable registers only
  typedef enum logic [2:0] {
    REG_GPIO_OUT,
    REG_GPIO_OE,
    REG_IRQ_EN,
    REG_IRQ_PEND,
    REG_MSIP
  } reg_idx_e;

  typedef struct packed {
    reg_idx_e  idx;
    mcu_word_t data;
  } reg_cmd_t;

  localparam mcu_addr_t ADDR_GPIO_OUT = 8'h00;
  localparam mcu_addr_t ADDR_GPIO_OE = 8'h04;
  localparam mcu_addr_t ADDR_GPIO_IN = 8'h08;
  localparam mcu_addr_t ADDR_IRQ_EN = 8'h0C;
  localparam mcu_addr_t ADDR_IRQ_PEND = 8'h10;
  localparam mcu_addr_t ADDR_MSIP = 8'h14;
  localparam mcu_addr_t ADDR_IRQ_VEC = 8'h18;

  localparam int CMD_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// File: verilog/mcu_pad_pkg.sv
// ====================
// mcu pad package
// GPIO widths, interrupt word layout and register view
// ====================
`default_nettype none

package mcu_pad_pkg;

  localparam int GPIO_W = 32;
  // pins 0..7 form the always-on bank
  localparam int GPIO_AO_W = 8;
  localparam int IRQ_W = 32;

  typedef logic [GPIO_W-1:0] gpio_word_t;
  typedef logic [GPIO_AO_W-1:0] gpio_ao_t;
  typedef logic [IRQ_W-1:0] irq_vector_t;

  // fixed positions in the core interrupt word
  localparam int IRQ_SOFTWARE_BIT = 3;
  localparam int IRQ_TIMER0_BIT = 7;
  localparam int IRQ_EXTERNAL_BIT = 11;
  localparam int IRQ_FAST_LSB = 16;
  localparam int FAST_W = 15;

  typedef logic [FAST_W-1:0] fast_irq_t;

  typedef struct packed {
    logic [3:0] timer;
    logic       dma_done;
    logic       spi;
    logic       spi_flash;
    logic       external;
  } irq_src_t;

  typedef struct packed {
    gpio_word_t  gpio_out;
    gpio_word_t  gpio_oe;
    gpio_word_t  gpio_in;
    gpio_ao_t    irq_en;
    gpio_ao_t    irq_pend;
    irq_vector_t msip;
    irq_vector_t irq_vec;
  } reg_view_t;

endpackage

`default_nettype wire

// File: verilog/mini_mcu_top.sv
// ====================
// mini mcu top
// APB front, command FIFO and GPIO/interrupt bank
// ====================
`timescale 1ns/1ps
`default_nettype none

module mini_mcu_top (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,
  input  wire mcu_bus_pkg::apb_req_t    apb_req_i,
  output mcu_bus_pkg::apb_rsp_t         apb_rsp_o,
  input  wire mcu_pad_pkg::gpio_word_t  gpio_i,
  output mcu_pad_pkg::gpio_word_t       gpio_o,
  output mcu_pad_pkg::gpio_word_t       gpio_oe_o,
  input  wire mcu_pad_pkg::irq_src_t    irq_src_i,
  output mcu_pad_pkg::irq_vector_t      irq_o
);

  import mcu_bus_pkg::*;
  import mcu_pad_pkg::*;

  reg_cmd_t  push_cmd;
  reg_cmd_t  head_cmd;
  reg_view_t view;
  logic      cmd_push;
  logic      cmd_pop;
  logic      cmd_valid;
  logic      fifo_full;
  logic      fifo_empty;

  apb_reg_front u_front (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .view_i       (view),
    .fifo_full_i  (fifo_full),
    .fifo_empty_i (fifo_empty),
    .cmd_o        (push_cmd),
    .cmd_push_o   (cmd_push)
  );

  cmd_fifo #(
    .DEPTH (CMD_FIFO_DEPTH)
  ) u_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (cmd_push),
    .data_i   (push_cmd),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty),
    .valid_o  (cmd_valid),
    .data_o   (head_cmd),
    .pop_i    (cmd_pop)
  );

  gpio_irq_bank u_bank (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (head_cmd),
    .cmd_pop_o   (cmd_pop),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o),
    .irq_src_i   (irq_src_i),
    .irq_o       (irq_o),
    .view_o      (view)
  );

endmodule

`default_nettype wire
